// File: sump_link.f
sump_pkg.sv
uart_rx.sv
uart_tx.sv
sump_cmd_decoder.sv
metadata_sender.sv
sump_link.sv
tb_sump_link.sv

// File: Makefile
# Verilator simulation of the SUMP host link

VERILATOR ?= verilator
TOP       ?= tb_sump_link
FILELIST  ?= sump_link.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal
EXTRA     ?=

.PHONY: sim clean

# The run exits non-zero when the testbench ends on $fatal
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb_sump_link.sv
`default_nettype none

module tb_sump_link;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 100;
  localparam int BIT_NS      = sump_pkg::CLKS_PER_BIT * CLK_PERIOD;
  localparam int FRAME_CLKS  = 10 * sump_pkg::CLKS_PER_BIT;
  // Host-side frame budget of each test for the watchdog
  localparam int FRAMES_IDLE  = 2;
  localparam int FRAMES_ID    = 1 + sump_pkg::ID_LEN + 1;
  localparam int FRAMES_META  = 2 + sump_pkg::META_LEN + 2;
  localparam int FRAMES_PAUSE = 3 + 1 + 5 + sump_pkg::META_LEN + 1;
  localparam int FRAMES_SKIP  = 6 + 4 + 4 + FRAMES_ID;
  localparam int TOTAL_FRAMES = FRAMES_IDLE + FRAMES_ID + FRAMES_META
                              + FRAMES_PAUSE + FRAMES_SKIP;
  localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * FRAME_CLKS * CLK_PERIOD * 2;

  logic   clock = 1'b0;
  logic   reset_n;
  logic   rx;
  logic   tx;
  logic   reply_busy;
  integer seed = 32'h58c1_3466;

  logic [7:0] rx_bytes[$];     // Bytes seen on tx
  time        rx_times[$];     // Mid-stop time of each byte

  sump_link uut (
    .clock      (clock),
    .reset_n    (reset_n),
    .rx         (rx),
    .tx         (tx),
    .reply_busy (reply_busy)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic end_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL: time %0d ns, %s = %0h, expected %0h", $time, name, actual, expected);
      end_with_failure();
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog: the run timed out after %0d ns", $time);
    end_with_failure();
  end

  // Host receiver sampling tx mid-bit on a falling clock edge
  initial begin : tx_monitor
    logic [7:0] data;
    wait (reset_n === 1'b1);
    forever begin
      @(negedge tx);
      #(BIT_NS / 2 + CLK_PERIOD / 2);
      if (tx !== 1'b0) report_error("start bit on tx ended before mid-bit");
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        data[i] = tx;                                   // LSB first
      end
      #(BIT_NS);
      if (tx !== 1'b1) report_error("stop bit on tx was not high");
      rx_bytes.push_back(data);
      rx_times.push_back($time);
    end
  end

  // One host frame on rx after a random idle gap
  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    int         gap;
    logic [9:0] frame;
    gap   = $unsigned($random(seed)) % 16;
    frame = {stop_bit, data, 1'b0};
    @(negedge clock);
    repeat (gap) @(negedge clock);
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (sump_pkg::CLKS_PER_BIT) @(negedge clock);
    end
    rx = 1'b1;                                          // Back to idle after a bad stop
  endtask

  task automatic idle_frames(input int count);
    repeat (count * FRAME_CLKS) @(negedge clock);
  endtask

  task automatic clear_reply();
    rx_bytes.delete();
    rx_times.delete();
  endtask

  task automatic wait_for_bytes(input int count, input int limit_clks, input string what);
    int waited;
    waited = 0;
    while (rx_bytes.size() < count && waited < limit_clks) begin
      @(negedge clock);
      waited++;
    end
    if (rx_bytes.size() < count) begin
      report_error($sformatf("%s: only %0d of %0d bytes arrived on tx",
                             what, rx_bytes.size(), count));
    end
  endtask

  task automatic wait_reply_level(input logic level, input string what);
    int waited;
    waited = 0;
    while (reply_busy !== level && waited < 2 * sump_pkg::CLKS_PER_BIT) begin
      @(negedge clock);
      waited++;
    end
    if (reply_busy !== level) report_error(what);
  endtask

  // Compare the received reply against the package table
  task automatic check_reply(input logic is_meta, input logic check_gaps);
    int         len;
    logic [7:0] expected;
    longint     idle_clks;
    len = is_meta ? sump_pkg::META_LEN : sump_pkg::ID_LEN;
    check_value("reply byte count", rx_bytes.size(), len);
    for (int i = 0; i < len; i++) begin
      if (is_meta) expected = sump_pkg::META_BYTES[i];
      else expected = sump_pkg::ID_BYTES[i];
      check_value($sformatf("reply byte %0d", i), rx_bytes[i], expected);
      if (check_gaps && i > 0) begin
        idle_clks = (rx_times[i] - rx_times[i-1]) / CLK_PERIOD - FRAME_CLKS;
        check_value($sformatf("tx idle clocks before byte %0d at most 2", i),
                    idle_clks <= 2, 1'b1);
      end
    end
  endtask

  task automatic idle_after_reset();
    repeat (20 * sump_pkg::CLKS_PER_BIT) begin
      @(negedge clock);
      check_value("tx", tx, 1'b1);
      check_value("reply_busy", reply_busy, 1'b0);
    end
  endtask

  task automatic identity_reply();
    clear_reply();
    send_byte(sump_pkg::CMD_ID, 1'b1);
    wait_for_bytes(sump_pkg::ID_LEN, (sump_pkg::ID_LEN + 1) * FRAME_CLKS, "identity reply");
    wait_reply_level(1'b0, "reply_busy stayed high after the identity reply");
    idle_frames(1);                                     // Nothing extra may follow
    check_reply(1'b0, 1'b1);
  endtask

  task automatic metadata_ignores_busy_request();
    clear_reply();
    send_byte(sump_pkg::CMD_METADATA, 1'b1);
    wait_reply_level(1'b1, "metadata reply did not start");
    send_byte(sump_pkg::CMD_ID, 1'b1);                  // Lands while busy
    check_value("reply_busy", reply_busy, 1'b1);
    wait_for_bytes(sump_pkg::META_LEN, (sump_pkg::META_LEN + 1) * FRAME_CLKS,
                   "metadata reply");
    wait_reply_level(1'b0, "reply_busy stayed high after the metadata reply");
    idle_frames(2);
    check_reply(1'b1, 1'b1);
  endtask

  task automatic pause_and_resume();
    int pause_at;
    int n_paused;
    int n_held;
    clear_reply();
    pause_at = 2 + $unsigned($random(seed)) % 16;
    send_byte(sump_pkg::CMD_METADATA, 1'b1);
    wait_for_bytes(pause_at, (pause_at + 1) * FRAME_CLKS, "metadata before XOFF");
    send_byte(sump_pkg::CMD_XOFF, 1'b1);
    n_paused = rx_bytes.size();
    idle_frames(1);                                     // Lets a byte in flight finish
    n_held = rx_bytes.size();
    check_value("at most one byte after XOFF", n_held <= n_paused + 1, 1'b1);
    idle_frames(5);
    check_value("byte count while paused", rx_bytes.size(), n_held);
    check_value("reply_busy", reply_busy, 1'b1);
    send_byte(sump_pkg::CMD_XON, 1'b1);
    wait_for_bytes(sump_pkg::META_LEN, (sump_pkg::META_LEN - n_held + 1) * FRAME_CLKS,
                   "metadata after XON");
    wait_reply_level(1'b0, "reply_busy stayed high after the resumed reply");
    idle_frames(1);
    check_reply(1'b1, 1'b0);
  endtask

  task automatic skip_args_and_bad_frame();
    clear_reply();
    send_byte(8'h80, 1'b1);                             // Long command whose args look like opcodes
    send_byte(sump_pkg::CMD_ID, 1'b1);
    send_byte(sump_pkg::CMD_METADATA, 1'b1);
    send_byte(sump_pkg::CMD_ID, 1'b1);
    send_byte(sump_pkg::CMD_METADATA, 1'b1);
    idle_frames(4);
    check_value("reply bytes after long command", rx_bytes.size(), 0);
    check_value("reply_busy", reply_busy, 1'b0);
    send_byte(sump_pkg::CMD_ID, 1'b0);
    idle_frames(4);
    check_value("reply bytes after bad stop bit", rx_bytes.size(), 0);
    check_value("reply_busy", reply_busy, 1'b0);
    identity_reply();
  endtask

  initial begin : main
    rx      = 1'b1;
    reset_n = 1'b0;
    repeat (16) @(negedge clock);
    reset_n = 1'b1;
    idle_after_reset();
    identity_reply();
    metadata_ignores_busy_request();
    pause_and_resume();
    skip_args_and_bad_frame();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sump_link.sv
`default_nettype none

module sump_link (
  input  logic clock,
  input  logic reset_n,
  input  logic rx,
  output logic tx,
  output logic reply_busy
);

  logic [7:0]            rx_byte;
  logic                  rx_valid;
  logic                  reply_start;
  sump_pkg::reply_kind_e reply_kind;
  logic                  paused;      // XOFF from the host
  logic                  tx_start;
  logic [7:0]            tx_data;
  logic                  tx_busy;

  uart_rx u_uart_rx (
    .clock    (clock),
    .reset_n  (reset_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  sump_cmd_decoder u_decoder (
    .clock       (clock),
    .reset_n     (reset_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .reply_start (reply_start),
    .reply_kind  (reply_kind),
    .paused      (paused)
  );

  metadata_sender u_sender (
    .clock       (clock),
    .reset_n     (reset_n),
    .reply_start (reply_start),
    .reply_kind  (reply_kind),
    .paused      (paused),
    .tx_busy     (tx_busy),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .reply_busy  (reply_busy)
  );

  uart_tx u_uart_tx (
    .clock    (clock),
    .reset_n  (reset_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

endmodule

`default_nettype wire

// File: metadata_sender.sv
`default_nettype none

module metadata_sender (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  reply_start,
  input  sump_pkg::reply_kind_e reply_kind,
  input  logic                  paused,
  input  logic                  tx_busy,
  output logic                  tx_start,
  output logic [7:0]            tx_data,
  output logic                  reply_busy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_WAIT_RISE,
    S_WAIT_FALL
  } send_state_e;

  send_state_e           state;
  sump_pkg::reply_kind_e kind_q;
  sump_pkg::meta_idx_t   idx;           // Byte position in the reply
  logic                  last_byte;

  assign last_byte = (kind_q == sump_pkg::REPLY_ID)
                   ? (idx == sump_pkg::meta_idx_t'(sump_pkg::ID_LEN - 1))
                   : (idx == sump_pkg::meta_idx_t'(sump_pkg::META_LEN - 1));

  assign tx_data = (kind_q == sump_pkg::REPLY_ID)
                 ? sump_pkg::ID_BYTES[idx[sump_pkg::ID_IDX_W-1:0]]
                 : sump_pkg::META_BYTES[idx];

  // Pause only holds off the next strobe, never a frame in flight
  assign tx_start   = (state == S_SEND) && !paused && !tx_busy;
  assign reply_busy = (state != S_IDLE);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state  <= S_IDLE;
      kind_q <= sump_pkg::REPLY_ID;
      idx    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          idx <= '0;
          if (reply_start) begin
            kind_q <= reply_kind;
            state  <= S_SEND;
          end
        end
        S_SEND: begin
          if (tx_start) state <= S_WAIT_RISE;
        end
        S_WAIT_RISE: begin
          if (tx_busy) state <= S_WAIT_FALL;      // Transmitter took the byte
        end
        S_WAIT_FALL: begin
          if (!tx_busy) begin
            if (last_byte) begin
              state <= S_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_SEND;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sump_cmd_decoder.sv
`default_nettype none

module sump_cmd_decoder (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_valid,
  output logic                  reply_start,
  output sump_pkg::reply_kind_e reply_kind,
  output logic                  paused
);

  typedef enum logic {
    DEC_OPCODE,
    DEC_ARGS
  } dec_state_e;

  dec_state_e state;
  logic [1:0] arg_cnt;        // Four argument bytes per long command

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state       <= DEC_OPCODE;
      arg_cnt     <= '0;
      reply_start <= 1'b0;
      paused      <= 1'b0;
    end else begin
      reply_start <= 1'b0;
      if (rx_valid) begin
        case (state)
          DEC_OPCODE: begin
            if (rx_byte[7]) begin
              state   <= DEC_ARGS;
              arg_cnt <= '0;
            end else begin
              case (sump_pkg::sump_opcode_e'(rx_byte))
                sump_pkg::CMD_ID,
                sump_pkg::CMD_METADATA: reply_start <= 1'b1;
                sump_pkg::CMD_XOFF:     paused <= 1'b1;
                sump_pkg::CMD_XON,
                sump_pkg::CMD_RESET:    paused <= 1'b0;
                default: ;                             // RUN and unknown codes
              endcase
            end
          end
          DEC_ARGS: begin
            arg_cnt <= arg_cnt + 1'b1;
            if (arg_cnt == 2'd3) state <= DEC_OPCODE;
          end
          default: state <= DEC_OPCODE;
        endcase
      end
    end
  end

  // Kind is only looked at together with reply_start
  always_ff @(posedge clock) begin
    if (rx_valid && state == DEC_OPCODE) begin
      reply_kind <= (rx_byte == sump_pkg::CMD_ID) ? sump_pkg::REPLY_ID
                                                  : sump_pkg::REPLY_META;
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx (
  input  logic       clock,
  input  logic       reset_n,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  output logic       tx,
  output logic       tx_busy
);

  logic [sump_pkg::FRAME_BITS-1:0] shift;    // Bit 0 is the line
  sump_pkg::clk_div_t              div;
  logic [3:0]                      bit_cnt;
  logic                            bit_end;

  assign bit_end = (div == sump_pkg::clk_div_t'(sump_pkg::CLKS_PER_BIT - 1));
  assign tx      = shift[0];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      shift   <= '1;                                 // Line idles high
      tx_busy <= 1'b0;
      div     <= '0;
      bit_cnt <= '0;
    end else if (!tx_busy) begin
      div     <= '0;
      bit_cnt <= '0;
      if (tx_start) begin
        shift   <= {1'b1, tx_data, 1'b0};            // Stop, data, start
        tx_busy <= 1'b1;
      end
    end else if (bit_end) begin
      div     <= '0;
      shift   <= {1'b1, shift[sump_pkg::FRAME_BITS-1:1]};
      bit_cnt <= bit_cnt + 1'b1;
      // Busy ends with the last cycle of the stop bit
      if (bit_cnt == 4'(sump_pkg::FRAME_BITS - 1)) tx_busy <= 1'b0;
    end else begin
      div <= div + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx (
  input  logic       clock,
  input  logic       reset_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e          state;
  logic               rx_meta;
  logic               rx_sync;
  logic               rx_prev;     // Previous synced level for edge detect
  sump_pkg::clk_div_t div;
  logic [2:0]         bit_cnt;
  logic [7:0]         shift;
  logic               half_bit;
  logic               full_bit;

  assign half_bit = (div == sump_pkg::clk_div_t'(sump_pkg::CLKS_PER_BIT / 2 - 1));
  assign full_bit = (div == sump_pkg::clk_div_t'(sump_pkg::CLKS_PER_BIT - 1));

  // Two-flop synchronizer plus one stage for the falling edge
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state    <= RX_IDLE;
      div      <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          div     <= '0;
          bit_cnt <= '0;
          if (rx_prev && !rx_sync) state <= RX_START;   // Start edge
        end
        RX_START: begin
          if (half_bit) begin
            div   <= '0;
            state <= rx_sync ? RX_IDLE : RX_DATA;       // Glitch check
          end else begin
            div <= div + 1'b1;
          end
        end
        RX_DATA: begin
          if (full_bit) begin
            div     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;
          end else begin
            div <= div + 1'b1;
          end
        end
        RX_STOP: begin
          if (full_bit) begin
            rx_valid <= rx_sync;                        // Low stop bit drops frame
            state    <= RX_IDLE;
          end else begin
            div <= div + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (state == RX_DATA && full_bit) shift <= {rx_sync, shift[7:1]};
    if (state == RX_STOP && full_bit) rx_byte <= shift;
  end

endmodule

`default_nettype wire

// File: sump_pkg.sv
`default_nettype none

package sump_pkg;

  // Serial timing
  localparam int CLKS_PER_BIT = 8;       // Clock cycles per serial bit
  localparam int FRAME_BITS   = 10;      // Start, eight data, stop
  localparam int CLK_DIV_W    = $clog2(CLKS_PER_BIT);

  typedef logic [CLK_DIV_W-1:0] clk_div_t;

  // Short SUMP opcodes; anything with bit 7 set is a long command
  typedef enum logic [7:0] {
    CMD_RESET    = 8'h00,
    CMD_RUN      = 8'h01,
    CMD_ID       = 8'h02,
    CMD_METADATA = 8'h04,
    CMD_XON      = 8'h11,
    CMD_XOFF     = 8'h13
  } sump_opcode_e;

  typedef enum logic {
    REPLY_ID,
    REPLY_META
  } reply_kind_e;

  // Identity reply, first byte first
  localparam int ID_LEN    = 4;
  localparam int ID_IDX_W  = $clog2(ID_LEN);
  localparam logic [7:0] ID_BYTES [ID_LEN] = '{"1", "A", "L", "S"};

  // Metadata reply, ends with a zero byte
  localparam int META_LEN   = 31;
  localparam int META_IDX_W = $clog2(META_LEN);

  typedef logic [META_IDX_W-1:0] meta_idx_t;

  localparam logic [7:0] META_BYTES [META_LEN] = '{
    8'h01,                                     // Device name
    "s", "u", "m", "p", " ", "l", "i", "n", "k",
    8'h00,
    8'h02,                                     // Firmware version
    "0", ".", "1",
    8'h00,
    8'h21,                                     // Sample memory, 16 KiB
    8'h00, 8'h00, 8'h40, 8'h00,
    8'h23,                                     // Max sample rate, 100 MHz
    8'h05, 8'hF5, 8'hE1, 8'h00,
    8'h40,                                     // Probe count
    8'h08,
    8'h41,                                     // Protocol version
    8'h02,
    8'h00                                      // End of table
  };

endpackage

`default_nettype wire
